// ==== logic/bp_harness_pkg.sv ====
// shared widths, address map and message types for the harness; import wherever a module needs them
package bp_harness_pkg;

   localparam int addr_width_gp = 32;
   localparam int data_width_gp = 64;

   // opcodes on every channel; finish only shows up on the boot record stream
   typedef enum logic [1:0]
   {
      e_mem_rd     = 2'b00,
      e_mem_wr     = 2'b01,
      e_mem_finish = 2'b11
   } mem_op_e;

   // command or response word, 98 bits
   typedef struct packed
   {
      mem_op_e                  op;
      logic [addr_width_gp-1:0] addr;
      logic [data_width_gp-1:0] data;
   } bp_mem_msg_s;

   // config space
   localparam logic [addr_width_gp-1:0] cfg_freeze_addr_gp     = 32'h0020_0008;
   localparam logic [addr_width_gp-1:0] cce_instr_base_addr_gp = 32'h0020_8000;

   // host endpoint
   localparam logic [addr_width_gp-1:0] host_putchar_addr_gp   = 32'h0010_1000;
   localparam logic [addr_width_gp-1:0] host_finish_addr_gp    = 32'h0010_2000;

   // console view, character in the low byte
   typedef struct packed
   {
      logic [55:0] pad;
      logic [7:0]  ch;
   } host_putchar_s;

   // finish view, core index above the exit code
   typedef struct packed
   {
      logic [31:0] core;
      logic [31:0] code;
   } host_finish_s;

   // data word of a host command, decoded by address
   typedef union packed
   {
      host_putchar_s putchar;
      host_finish_s  finish;
   } host_payload_u;

endpackage

// ==== logic/bp_cfg_loader.sv ====
// configuration loader that freezes the core, fills the CCE instruction RAM and flags completion
`timescale 1ns/1ps

module bp_cfg_loader
   import bp_harness_pkg::*;
#(
   parameter int num_cce_instr_p = 8
)
(
   input  logic        clk_i,
   input  logic        rst_n_i,

   output bp_mem_msg_s cmd_o,
   output logic        cmd_v_o,
   input  logic        cmd_ready_i,

   input  logic        resp_v_i,

   output logic        done_o
);

   // freeze write plus one write per instruction word
   localparam int total_lp     = num_cce_instr_p + 1;
   localparam int cnt_width_lp = $clog2(total_lp + 1);

   logic [cnt_width_lp-1:0] idx_r;
   logic [cnt_width_lp-1:0] instr_idx;
   logic [cnt_width_lp-1:0] out_r;
   logic [cnt_width_lp-1:0] out_n;
   logic                    cmd_v_r;
   logic                    done_r;
   logic                    xfer;
   logic                    last_xfer;
   logic                    issued_n;

   assign xfer      = cmd_v_r & cmd_ready_i;
   assign last_xfer = xfer & (idx_r == cnt_width_lp'(num_cce_instr_p));
   assign issued_n  = (idx_r == cnt_width_lp'(total_lp)) | last_xfer;
   assign out_n     = out_r + cnt_width_lp'(xfer) - cnt_width_lp'(resp_v_i);
   assign instr_idx = idx_r - 1'b1;

   // index 0 is the freeze, index i+1 is instruction word i
   always_comb
   begin
      cmd_o    = '0;
      cmd_o.op = e_mem_wr;
      if (idx_r == '0)
      begin
         cmd_o.addr = cfg_freeze_addr_gp;
         cmd_o.data = data_width_gp'(1);
      end
      else
      begin
         cmd_o.addr = cce_instr_base_addr_gp + (addr_width_gp'(instr_idx) << 3);
         cmd_o.data = data_width_gp'(instr_idx);
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         idx_r   <= '0;
         cmd_v_r <= 1'b0;
         out_r   <= '0;
         done_r  <= 1'b0;
      end
      else
      begin
         out_r  <= out_n;
         done_r <= done_r | (issued_n & (out_n == '0));
         if (xfer)
         begin
            idx_r   <= idx_r + 1'b1;
            cmd_v_r <= ~last_xfer;
         end
         else if (!cmd_v_r && idx_r == '0)
         begin
            // first cycle out of reset
            cmd_v_r <= 1'b1;
         end
      end
   end

   assign cmd_v_o = cmd_v_r;
   assign done_o  = done_r;

endmodule

// ==== logic/bp_nbf_loader.sv ====
// boot record loader that replays records as commands once started and ends with the freeze clear
`timescale 1ns/1ps

module bp_nbf_loader
   import bp_harness_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        start_i,

   input  bp_mem_msg_s nbf_i,
   input  logic        nbf_v_i,
   output logic        nbf_ready_o,

   output bp_mem_msg_s cmd_o,
   output logic        cmd_v_o,
   input  logic        cmd_ready_i,

   input  logic        resp_v_i,

   output logic        done_o
);

   localparam int out_width_lp = 8;

   bp_mem_msg_s             rec_cmd;
   bp_mem_msg_s             cmd_r;
   logic                    cmd_v_r;
   logic                    cmd_v_n;
   logic                    fin_r;
   logic                    fin_n;
   logic                    done_r;
   logic                    accept;
   logic                    xfer;
   logic [out_width_lp-1:0] out_r;
   logic [out_width_lp-1:0] out_n;

   // no new record while one is waiting or after the finish
   assign nbf_ready_o = start_i & ~cmd_v_r & ~fin_r;
   assign accept      = nbf_v_i & nbf_ready_o;
   assign xfer        = cmd_v_r & cmd_ready_i;

   // finish record becomes the freeze clear
   always_comb
   begin
      rec_cmd = nbf_i;
      if (nbf_i.op == e_mem_finish)
      begin
         rec_cmd.op   = e_mem_wr;
         rec_cmd.addr = cfg_freeze_addr_gp;
         rec_cmd.data = '0;
      end
   end

   assign cmd_v_n = accept | (cmd_v_r & ~xfer);
   assign fin_n   = fin_r | (accept & (nbf_i.op == e_mem_finish));
   assign out_n   = out_r + out_width_lp'(xfer) - out_width_lp'(resp_v_i);

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         cmd_v_r <= 1'b0;
         fin_r   <= 1'b0;
         out_r   <= '0;
         done_r  <= 1'b0;
      end
      else
      begin
         cmd_v_r <= cmd_v_n;
         fin_r   <= fin_n;
         out_r   <= out_n;
         done_r  <= done_r | (fin_n & ~cmd_v_n & (out_n == '0));
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (accept)
         cmd_r <= rec_cmd;
   end

   assign cmd_o   = cmd_r;
   assign cmd_v_o = cmd_v_r;
   assign done_o  = done_r;

endmodule

// ==== logic/bp_load_sequencer.sv ====
// runs the config loader then the boot loader over the one shared load port
`timescale 1ns/1ps

module bp_load_sequencer
   import bp_harness_pkg::*;
#(
   parameter int num_cce_instr_p = 8
)
(
   input  logic        clk_i,
   input  logic        rst_n_i,

   input  bp_mem_msg_s nbf_i,
   input  logic        nbf_v_i,
   output logic        nbf_ready_o,

   output bp_mem_msg_s load_cmd_o,
   output logic        load_cmd_v_o,
   input  logic        load_cmd_ready_i,

   input  bp_mem_msg_s load_resp_i,
   input  logic        load_resp_v_i,
   output logic        load_resp_ready_o,

   output logic        load_done_o
);

   bp_mem_msg_s cfg_cmd_lo;
   bp_mem_msg_s nbf_cmd_lo;
   logic        cfg_cmd_v_lo;
   logic        nbf_cmd_v_lo;
   logic        cfg_done_lo;
   logic        resp_v_li;

   // a finish opcode never comes back as a response, drop it
   assign resp_v_li         = load_resp_v_i & (load_resp_i.op != e_mem_finish);
   assign load_resp_ready_o = 1'b1;

   bp_cfg_loader
   #(
      .num_cce_instr_p(num_cce_instr_p)
   )
   cfg_loader
   (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cmd_o       (cfg_cmd_lo),
      .cmd_v_o     (cfg_cmd_v_lo),
      .cmd_ready_i (load_cmd_ready_i & ~cfg_done_lo),
      .resp_v_i    (resp_v_li & ~cfg_done_lo),
      .done_o      (cfg_done_lo)
   );

   bp_nbf_loader nbf_loader
   (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .start_i     (cfg_done_lo),
      .nbf_i       (nbf_i),
      .nbf_v_i     (nbf_v_i),
      .nbf_ready_o (nbf_ready_o),
      .cmd_o       (nbf_cmd_lo),
      .cmd_v_o     (nbf_cmd_v_lo),
      .cmd_ready_i (load_cmd_ready_i & cfg_done_lo),
      .resp_v_i    (resp_v_li & cfg_done_lo),
      .done_o      (load_done_o)
   );

   // loaders never overlap, so a fixed hand-over is enough
   assign load_cmd_o   = cfg_done_lo ? nbf_cmd_lo : cfg_cmd_lo;
   assign load_cmd_v_o = cfg_done_lo ? nbf_cmd_v_lo : cfg_cmd_v_lo;

endmodule

// ==== logic/bp_host.sv ====
// host endpoint for processor I/O writes, console characters and per-core finish flags
`timescale 1ns/1ps

module bp_host
   import bp_harness_pkg::*;
#(
   parameter int num_core_p = 2
)
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,

   input  bp_mem_msg_s           io_cmd_i,
   input  logic                  io_cmd_v_i,
   output logic                  io_cmd_ready_o,

   output bp_mem_msg_s           io_resp_o,
   output logic                  io_resp_v_o,
   input  logic                  io_resp_ready_i,

   output logic [num_core_p-1:0] program_finish_o
);

   host_payload_u         payload_li;
   bp_mem_msg_s           resp_n;
   bp_mem_msg_s           resp_r;
   logic                  resp_v_r;
   logic                  accept;
   logic                  finish_wr;
   logic [num_core_p-1:0] finish_r;

   assign payload_li     = io_cmd_i.data;
   assign io_cmd_ready_o = ~resp_v_r | io_resp_ready_i;
   assign accept         = io_cmd_v_i & io_cmd_ready_o;
   assign finish_wr      = accept & (io_cmd_i.op == e_mem_wr)
                           & (io_cmd_i.addr == host_finish_addr_gp);

   // putchar needs nothing beyond the response here
   always_comb
   begin
      resp_n      = io_cmd_i;
      resp_n.data = '0;
      if (io_cmd_i.op == e_mem_rd && io_cmd_i.addr == host_finish_addr_gp)
         resp_n.data = data_width_gp'(finish_r);
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         resp_v_r <= 1'b0;
         finish_r <= '0;
      end
      else
      begin
         if (accept)
            resp_v_r <= 1'b1;
         else if (io_resp_ready_i)
            resp_v_r <= 1'b0;
         // sticky per core, out of range index is ignored
         for (int i = 0; i < num_core_p; i++)
         begin
            if (finish_wr && payload_li.finish.core == 32'(i))
               finish_r[i] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (accept)
         resp_r <= resp_n;
   end

   assign io_resp_o        = resp_r;
   assign io_resp_v_o      = resp_v_r;
   assign program_finish_o = finish_r;

endmodule

// ==== logic/bp_mem.sv ====
// fixed latency word memory model with a response pipeline that stalls as a whole
`timescale 1ns/1ps

module bp_mem
   import bp_harness_pkg::*;
#(
   parameter int mem_latency_p = 3,
   parameter int mem_els_p     = 256
)
(
   input  logic        clk_i,
   input  logic        rst_n_i,

   input  bp_mem_msg_s mem_cmd_i,
   input  logic        mem_cmd_v_i,
   output logic        mem_cmd_ready_o,

   output bp_mem_msg_s mem_resp_o,
   output logic        mem_resp_v_o,
   input  logic        mem_resp_ready_i
);

   localparam int idx_width_lp = (mem_els_p > 1) ? $clog2(mem_els_p) : 1;

   logic [data_width_gp-1:0] mem_r [mem_els_p] = '{default: '0};

   bp_mem_msg_s              pipe_r   [mem_latency_p];
   logic [mem_latency_p-1:0] pipe_v_r;
   bp_mem_msg_s              resp_n;
   logic [idx_width_lp-1:0]  idx;
   logic                     stall;
   logic                     accept;

   // a held response freezes every stage
   assign stall           = mem_resp_v_o & ~mem_resp_ready_i;
   assign mem_cmd_ready_o = ~stall;
   assign accept          = mem_cmd_v_i & mem_cmd_ready_o;

   // address is a word index
   assign idx = idx_width_lp'(mem_cmd_i.addr % addr_width_gp'(mem_els_p));

   always_comb
   begin
      resp_n      = mem_cmd_i;
      resp_n.data = '0;
      if (mem_cmd_i.op == e_mem_rd)
         resp_n.data = mem_r[idx];
   end

   always_ff @(posedge clk_i)
   begin
      if (accept && mem_cmd_i.op == e_mem_wr)
         mem_r[idx] <= mem_cmd_i.data;
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         pipe_v_r <= '0;
      end
      else if (!stall)
      begin
         pipe_v_r[0] <= accept;
         for (int s = 1; s < mem_latency_p; s++)
         begin
            pipe_v_r[s] <= pipe_v_r[s-1];
         end
      end
   end

   // payload stages, no reset
   always_ff @(posedge clk_i)
   begin
      if (!stall)
      begin
         pipe_r[0] <= resp_n;
         for (int s = 1; s < mem_latency_p; s++)
         begin
            pipe_r[s] <= pipe_r[s-1];
         end
      end
   end

   assign mem_resp_o   = pipe_r[mem_latency_p-1];
   assign mem_resp_v_o = pipe_v_r[mem_latency_p-1];

endmodule

// ==== logic/bp_harness_top.sv ====
// top level of the harness, load sequencing, host endpoint and memory model side by side
`timescale 1ns/1ps

module bp_harness_top
   import bp_harness_pkg::*;
#(
   parameter int num_cce_instr_p = 8,
   parameter int mem_latency_p   = 3,
   parameter int mem_els_p       = 256,
   parameter int num_core_p      = 2
)
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,

   input  bp_mem_msg_s           nbf_i,
   input  logic                  nbf_v_i,
   output logic                  nbf_ready_o,

   output bp_mem_msg_s           load_cmd_o,
   output logic                  load_cmd_v_o,
   input  logic                  load_cmd_ready_i,
   input  bp_mem_msg_s           load_resp_i,
   input  logic                  load_resp_v_i,
   output logic                  load_resp_ready_o,

   input  bp_mem_msg_s           io_cmd_i,
   input  logic                  io_cmd_v_i,
   output logic                  io_cmd_ready_o,
   output bp_mem_msg_s           io_resp_o,
   output logic                  io_resp_v_o,
   input  logic                  io_resp_ready_i,

   input  bp_mem_msg_s           mem_cmd_i,
   input  logic                  mem_cmd_v_i,
   output logic                  mem_cmd_ready_o,
   output bp_mem_msg_s           mem_resp_o,
   output logic                  mem_resp_v_o,
   input  logic                  mem_resp_ready_i,

   output logic                  load_done_o,
   output logic [num_core_p-1:0] program_finish_o
);

   bp_load_sequencer
   #(
      .num_cce_instr_p(num_cce_instr_p)
   )
   load_seq
   (
      .clk_i             (clk_i),
      .rst_n_i           (rst_n_i),
      .nbf_i             (nbf_i),
      .nbf_v_i           (nbf_v_i),
      .nbf_ready_o       (nbf_ready_o),
      .load_cmd_o        (load_cmd_o),
      .load_cmd_v_o      (load_cmd_v_o),
      .load_cmd_ready_i  (load_cmd_ready_i),
      .load_resp_i       (load_resp_i),
      .load_resp_v_i     (load_resp_v_i),
      .load_resp_ready_o (load_resp_ready_o),
      .load_done_o       (load_done_o)
   );

   bp_host
   #(
      .num_core_p(num_core_p)
   )
   host
   (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .io_cmd_i         (io_cmd_i),
      .io_cmd_v_i       (io_cmd_v_i),
      .io_cmd_ready_o   (io_cmd_ready_o),
      .io_resp_o        (io_resp_o),
      .io_resp_v_o      (io_resp_v_o),
      .io_resp_ready_i  (io_resp_ready_i),
      .program_finish_o (program_finish_o)
   );

   bp_mem
   #(
      .mem_latency_p(mem_latency_p),
      .mem_els_p    (mem_els_p)
   )
   mem
   (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .mem_cmd_i        (mem_cmd_i),
      .mem_cmd_v_i      (mem_cmd_v_i),
      .mem_cmd_ready_o  (mem_cmd_ready_o),
      .mem_resp_o       (mem_resp_o),
      .mem_resp_v_o     (mem_resp_v_o),
      .mem_resp_ready_i (mem_resp_ready_i)
   );

endmodule

// ==== verification/bp_harness_checker.sv ====
// handshake and status assertions for the harness, bound into the top level by the bind below
`timescale 1ns/1ps

module bp_harness_checker
   import bp_harness_pkg::*;
#(
   parameter int num_core_p = 2
)
(
   input logic                  clk_i,
   input logic                  rst_n_i,

   input bp_mem_msg_s           load_cmd_i,
   input logic                  load_cmd_v_i,
   input logic                  load_cmd_ready_i,

   input bp_mem_msg_s           io_resp_i,
   input logic                  io_resp_v_i,
   input logic                  io_resp_ready_i,

   input bp_mem_msg_s           mem_resp_i,
   input logic                  mem_resp_v_i,
   input logic                  mem_resp_ready_i,

   input logic                  load_done_i,
   input logic [num_core_p-1:0] program_finish_i
);

   // failed assertion count
   int fail_cnt = 0;

   // a valid stays up with the same payload until it is taken
   load_cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      load_cmd_v_i && !load_cmd_ready_i |=> load_cmd_v_i && $stable(load_cmd_i))
   else
   begin
      fail_cnt++;
      $error("load command dropped or changed before it was taken");
   end

   io_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      io_resp_v_i && !io_resp_ready_i |=> io_resp_v_i && $stable(io_resp_i))
   else
   begin
      fail_cnt++;
      $error("host response dropped or changed before it was taken");
   end

   mem_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_resp_v_i && !mem_resp_ready_i |=> mem_resp_v_i && $stable(mem_resp_i))
   else
   begin
      fail_cnt++;
      $error("memory response dropped or changed before it was taken");
   end

   // sticky status
   load_done_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !$fell(load_done_i))
   else
   begin
      fail_cnt++;
      $error("load done fell");
   end

   finish_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (program_finish_i & $past(program_finish_i)) == $past(program_finish_i))
   else
   begin
      fail_cnt++;
      $error("a program finish flag fell");
   end

endmodule

bind bp_harness_top bp_harness_checker
#(
   .num_core_p(num_core_p)
)
harness_chk
(
   .clk_i            (clk_i),
   .rst_n_i          (rst_n_i),
   .load_cmd_i       (load_cmd_o),
   .load_cmd_v_i     (load_cmd_v_o),
   .load_cmd_ready_i (load_cmd_ready_i),
   .io_resp_i        (io_resp_o),
   .io_resp_v_i      (io_resp_v_o),
   .io_resp_ready_i  (io_resp_ready_i),
   .mem_resp_i       (mem_resp_o),
   .mem_resp_v_i     (mem_resp_v_o),
   .mem_resp_ready_i (mem_resp_ready_i),
   .load_done_i      (load_done_o),
   .program_finish_i (program_finish_o)
);

// ==== verification/bp_harness_tb.sv ====
// directed testbench for the harness top level; runs load, boot, memory and host tests in turn
`timescale 1ns/1ps

module bp_harness_tb
   import bp_harness_pkg::*;
();

   localparam int num_cce_instr_lp = 8;
   localparam int mem_latency_lp   = 3;
   localparam int mem_els_lp       = 256;
   localparam int num_core_lp      = 2;
   localparam int mem_stream_lp    = 24;

   // cycle budget per test, back-pressure runs get the worst LFSR zero run
   localparam int reset_cycles_lp  = 2 * 18;
   localparam int cfg_cycles_lp    = 12 + 200;
   localparam int boot_cycles_lp   = 60;
   localparam int mem_cycles_lp    = 16 * 5 + 400;
   localparam int host_cycles_lp   = 30;
   localparam int budget_ns_lp     = 40 * (reset_cycles_lp + cfg_cycles_lp + boot_cycles_lp
                                     + mem_cycles_lp + host_cycles_lp + 10) + 4000;

   logic                   clk            = 1'b0;
   logic                   rst_n          = 1'b0;
   bp_mem_msg_s            nbf            = '0;
   logic                   nbf_v          = 1'b0;
   logic                   load_cmd_ready = 1'b1;
   bp_mem_msg_s            load_resp      = '0;
   logic                   load_resp_v    = 1'b0;
   bp_mem_msg_s            io_cmd         = '0;
   logic                   io_cmd_v       = 1'b0;
   logic                   io_resp_ready  = 1'b1;
   bp_mem_msg_s            mem_cmd        = '0;
   logic                   mem_cmd_v      = 1'b0;
   logic                   mem_resp_ready = 1'b1;
   logic                   nbf_ready;
   bp_mem_msg_s            load_cmd;
   logic                   load_cmd_v;
   logic                   load_resp_ready;
   logic                   io_cmd_ready;
   bp_mem_msg_s            io_resp;
   logic                   io_resp_v;
   logic                   mem_cmd_ready;
   bp_mem_msg_s            mem_resp;
   logic                   mem_resp_v;
   logic                   load_done;
   logic [num_core_lp-1:0] program_finish;

   logic [15:0]            lfsr = 16'd33;
   logic [63:0]            mem_model [mem_els_lp] = '{default: '0};
   bp_mem_msg_s            first_rec;

   always #20 clk = ~clk;

   bp_harness_top
   #(
      .num_cce_instr_p(num_cce_instr_lp),
      .mem_latency_p  (mem_latency_lp),
      .mem_els_p      (mem_els_lp),
      .num_core_p     (num_core_lp)
   )
   bp_harness_top_i
   (
      .clk_i(clk), .rst_n_i(rst_n),
      .nbf_i(nbf), .nbf_v_i(nbf_v), .nbf_ready_o(nbf_ready),
      .load_cmd_o(load_cmd), .load_cmd_v_o(load_cmd_v), .load_cmd_ready_i(load_cmd_ready),
      .load_resp_i(load_resp), .load_resp_v_i(load_resp_v),
      .load_resp_ready_o(load_resp_ready),
      .io_cmd_i(io_cmd), .io_cmd_v_i(io_cmd_v), .io_cmd_ready_o(io_cmd_ready),
      .io_resp_o(io_resp), .io_resp_v_o(io_resp_v), .io_resp_ready_i(io_resp_ready),
      .mem_cmd_i(mem_cmd), .mem_cmd_v_i(mem_cmd_v), .mem_cmd_ready_o(mem_cmd_ready),
      .mem_resp_o(mem_resp), .mem_resp_v_o(mem_resp_v), .mem_resp_ready_i(mem_resp_ready),
      .load_done_o(load_done), .program_finish_o(program_finish)
   );

   task automatic stop_run(input string what);
      $display("%s", what);
      $display("Checks failed");
      $fatal(1, "simulation stopped on the first error");
   endtask

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v[i] = lfsr[0];
      end
      return v;
   endfunction

   function automatic logic rand_bit();
      logic [63:0] v;
      v = rand_bits(1);
      return v[0];
   endfunction

   function automatic bp_mem_msg_s mk_msg(input mem_op_e op, input logic [31:0] addr,
                                          input logic [63:0] data);
      bp_mem_msg_s m;
      m.op   = op;
      m.addr = addr;
      m.data = data;
      return m;
   endfunction

   // freeze write first, then instruction word i at base plus 8i
   function automatic bp_mem_msg_s cfg_expected(input int i);
      if (i == 0)
         return mk_msg(e_mem_wr, cfg_freeze_addr_gp, 64'd1);
      return mk_msg(e_mem_wr, cce_instr_base_addr_gp + 32'(8 * (i - 1)), 64'(i - 1));
   endfunction

   // reference memory, updated once per accepted command
   function automatic bp_mem_msg_s mem_apply(input bp_mem_msg_s cmd);
      bp_mem_msg_s r;
      int          idx;
      idx = int'(cmd.addr % mem_els_lp);
      r   = mk_msg(cmd.op, cmd.addr, '0);
      if (cmd.op == e_mem_rd)
         r.data = mem_model[idx];
      else
         mem_model[idx] = cmd.data;
      return r;
   endfunction

   function automatic bp_mem_msg_s rand_mem_cmd();
      mem_op_e op;
      op = rand_bit() ? e_mem_wr : e_mem_rd;
      return mk_msg(op, 32'(rand_bits(4)), rand_bits(64));
   endfunction

   task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp)
      else stop_run($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp));
   endtask

   task automatic check_msg(input string what, input bp_mem_msg_s got, input bp_mem_msg_s exp);
      assert (got === exp)
      else stop_run($sformatf("ERROR at %0t ns: %s is %0d/%h/%h, expected %0d/%h/%h",
                              $time, what, got.op, got.addr, got.data,
                              exp.op, exp.addr, exp.data));
   endtask

   // outside side of the load port, answers each command in the next cycle
   always @(posedge clk)
   begin
      load_resp_v <= load_cmd_v && load_cmd_ready;
      load_resp   <= mk_msg(load_cmd.op, load_cmd.addr, '0);
   end

   always @(posedge clk)
   begin
      if (bp_harness_top_i.harness_chk.fail_cnt != 0)
         stop_run("a handshake or status assertion in the checker failed");
   end

   task automatic apply_reset();
      rst_n <= 1'b0;
      repeat (16) @(posedge clk);
      check_val("valid and status outputs in reset",
                {load_cmd_v, io_resp_v, mem_resp_v, load_done, program_finish}, '0);
      rst_n <= 1'b1;
   endtask

   task automatic run_config(input bit random_ready);
      int n;
      int cyc;
      n   = 0;
      cyc = 0;
      while (n < num_cce_instr_lp + 1)
      begin
         @(posedge clk);
         cyc++;
         check_val("nbf ready during config", nbf_ready, 0);
         check_val("load response ready", load_resp_ready, 1);
         if (load_cmd_v && load_cmd_ready)
         begin
            check_msg($sformatf("config command %0d", n), load_cmd, cfg_expected(n));
            n++;
         end
         load_cmd_ready <= random_ready ? rand_bit() : 1'b1;
      end
      // one command per cycle from the first cycle after reset
      if (!random_ready)
         check_val("config cycles", cyc, num_cce_instr_lp + 2);
      load_cmd_ready <= 1'b1;
   endtask

   task automatic boot_record(input bp_mem_msg_s rec, input bp_mem_msg_s exp);
      int lat;
      nbf   <= rec;
      nbf_v <= 1'b1;
      do
         @(posedge clk);
      while (!(nbf_v && nbf_ready));
      nbf_v <= 1'b0;
      lat = 0;
      do
      begin
         @(posedge clk);
         lat++;
      end
      while (!(load_cmd_v && load_cmd_ready));
      check_val("cycles from boot record to command", lat, 1);
      check_msg("boot command", load_cmd, exp);
   endtask

   task automatic test_boot(input bp_mem_msg_s first);
      bp_mem_msg_s rec;
      int          lat;
      for (int i = 0; i < 3; i++)
      begin
         rec = (i == 0) ? first : mk_msg(e_mem_wr, 32'h8000_0000 + 32'(rand_bits(12)),
                                         rand_bits(64));
         boot_record(rec, rec);
         check_val("load done before finish", load_done, 0);
      end
      rec = mk_msg(e_mem_finish, '0, rand_bits(64));
      boot_record(rec, mk_msg(e_mem_wr, cfg_freeze_addr_gp, '0));
      lat = 0;
      do
      begin
         @(posedge clk);
         lat++;
      end
      while (!load_done);
      check_val("cycles from freeze clear to load done", lat, 2);
   endtask

   task automatic mem_single(input bp_mem_msg_s cmd);
      bp_mem_msg_s exp;
      int          lat;
      mem_cmd   <= cmd;
      mem_cmd_v <= 1'b1;
      do
         @(posedge clk);
      while (!(mem_cmd_v && mem_cmd_ready));
      exp       = mem_apply(mem_cmd);
      mem_cmd_v <= 1'b0;
      lat = 0;
      do
      begin
         @(posedge clk);
         lat++;
      end
      while (!mem_resp_v);
      check_val("memory latency", lat, mem_latency_lp);
      check_msg("memory response", mem_resp, exp);
   endtask

   task automatic test_mem();
      logic [31:0] addrs [8];
      bp_mem_msg_s exp_q [$];
      int          sent;
      int          got;
      mem_resp_ready <= 1'b1;
      for (int i = 0; i < 8; i++)
      begin
         addrs[i] = 32'(rand_bits(10));
         mem_single(mk_msg(e_mem_wr, addrs[i], rand_bits(64)));
      end
      for (int i = 0; i < 8; i++)
         mem_single(mk_msg(e_mem_rd, addrs[i], '0));
      // back-to-back stream under random back-pressure
      sent      = 0;
      got       = 0;
      mem_cmd   <= rand_mem_cmd();
      mem_cmd_v <= 1'b1;
      while (got < mem_stream_lp)
      begin
         @(posedge clk);
         if (mem_resp_v && !mem_resp_ready)
            check_val("memory command ready while response stalled", mem_cmd_ready, 0);
         if (mem_cmd_v && mem_cmd_ready)
         begin
            exp_q.push_back(mem_apply(mem_cmd));
            sent++;
            mem_cmd_v <= (sent < mem_stream_lp);
            mem_cmd   <= rand_mem_cmd();
         end
         if (mem_resp_v && mem_resp_ready)
         begin
            assert (exp_q.size() != 0)
            else stop_run("memory returned a response with no command in flight");
            check_msg("streamed memory response", mem_resp, exp_q.pop_front());
            got++;
         end
         mem_resp_ready <= rand_bit();
      end
      mem_resp_ready <= 1'b1;
      repeat (mem_latency_lp + 1)
      begin
         @(posedge clk);
         check_val("extra memory response", mem_resp_v, 0);
      end
   endtask

   task automatic host_write(input logic [31:0] addr, input host_payload_u pl,
                             input logic [num_core_lp-1:0] exp_fin, input int hold);
      int lat;
      io_cmd        <= mk_msg(e_mem_wr, addr, pl);
      io_cmd_v      <= 1'b1;
      io_resp_ready <= (hold == 0);
      do
         @(posedge clk);
      while (!(io_cmd_v && io_cmd_ready));
      io_cmd_v <= 1'b0;
      lat = 0;
      do
      begin
         @(posedge clk);
         lat++;
      end
      while (!io_resp_v);
      check_val("host latency", lat, 1);
      check_msg("host response", io_resp, mk_msg(e_mem_wr, addr, '0));
      check_val("program finish flags", program_finish, exp_fin);
      // response stays up and blocks new commands until consumed
      for (int i = 0; i < hold; i++)
      begin
         @(posedge clk);
         check_val("held host response valid", io_resp_v, 1);
         check_val("host command ready while response held", io_cmd_ready, 0);
      end
      io_resp_ready <= 1'b1;
      if (hold > 0)
         @(posedge clk);
   endtask

   task automatic test_host();
      host_payload_u pl;
      pl            = '0;
      pl.putchar.ch = 8'h41;
      host_write(host_putchar_addr_gp, pl, 2'b00, 1 + int'(rand_bits(2)));
      pl             = '0;
      pl.finish.core = 32'd1;
      pl.finish.code = 32'(rand_bits(8));
      host_write(host_finish_addr_gp, pl, 2'b10, 0);
      pl.finish.core = 32'd0;
      host_write(host_finish_addr_gp, pl, 2'b11, 0);
   endtask

   initial
   begin
      #(budget_ns_lp);
      stop_run("timeout: the tests did not reach their end in time");
   end

   initial
   begin
      // first boot record waits on nbf while the config loader runs
      first_rec = mk_msg(e_mem_wr, 32'h8000_0000, rand_bits(64));
      @(posedge clk);
      nbf   <= first_rec;
      nbf_v <= 1'b1;
      apply_reset();
      run_config(1'b0);
      test_boot(first_rec);
      test_mem();
      test_host();
      apply_reset();
      run_config(1'b1);
      repeat (4) @(posedge clk);
      if (bp_harness_top_i.harness_chk.fail_cnt == 0)
      begin
         $display("All checks passed");
         $finish;
      end
      else
      begin
         stop_run("a handshake or status assertion in the checker failed");
      end
   end

endmodule

// ==== bp_harness_top.f ====
logic/bp_harness_pkg.sv
logic/bp_cfg_loader.sv
logic/bp_nbf_loader.sv
logic/bp_load_sequencer.sv
logic/bp_host.sv
logic/bp_mem.sv
logic/bp_harness_top.sv
verification/bp_harness_checker.sv
verification/bp_harness_tb.sv

// ==== Bender.yml ====
package:
  name: bp_harness

sources:
  - logic/bp_harness_pkg.sv
  - logic/bp_cfg_loader.sv
  - logic/bp_nbf_loader.sv
  - logic/bp_load_sequencer.sv
  - logic/bp_host.sv
  - logic/bp_mem.sv
  - logic/bp_harness_top.sv
  - target: test
    files:
      - verification/bp_harness_checker.sv
      - verification/bp_harness_tb.sv
